//--- flist.f
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/insn_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/lsu.sv
hdl/riscv_core.sv
verification/riscv_core_properties.sv
verification/riscv_core_tb.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/rv_core_pkg.sv
  - hdl/insn_decoder.sv
  - hdl/reg_file.sv
  - hdl/alu.sv
  - hdl/pc_unit.sv
  - hdl/lsu.sv
  - hdl/riscv_core.sv
  - target: test
    files:
      - verification/riscv_core_properties.sv
      - verification/riscv_core_tb.sv

//--- verification/riscv_core_tb.sv
`timescale 1ns/100ps

module riscv_core_tb;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  // data base pointer held in x1
  localparam word_t BASE = 32'h0000_1000;

  // one program row with the pc the core must hold when it is presented
  typedef struct packed {
    word_t    pc;
    word_t    insn;
    word_t    load_data;
    word_t    addr;
    word_t    wdata;
    byte_en_t be;
    logic     halt;
    logic     mem_check;
  } row_t;

  logic      clk;
  logic      rst;
  word_t     insn;
  word_t     load_data;
  word_t     pc;
  dmem_req_t dmem;
  logic      halt;

  row_t  rows [$];
  word_t prog_pc = '0;
  word_t lfsr = 32'ha6d8;
  logic  table_ready = 1'b0;
  int    checks = 0;
  int    errors = 0;

  riscv_core u_riscv_core (
    .clk       (clk),
    .rst       (rst),
    .insn      (insn),
    .load_data (load_data),
    .pc        (pc),
    .dmem      (dmem),
    .halt      (halt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // instruction formats
  function automatic word_t r_type(input funct7_t f7, input funct3_t f3, input reg_addr_t rd,
                                   input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t i_type(input opcode_t op, input funct3_t f3, input reg_addr_t rd,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input funct3_t f3, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t b_type(input funct3_t f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t u_type(input opcode_t op, input reg_addr_t rd,
                                   input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // taps 32, 22, 2, 1
  function automatic word_t lfsr_next(input word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output word_t w);
    for (int b = 0; b < 32; b++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  // architectural load result for a lane offset
  function automatic word_t expect_load(input word_t w, input funct3_t f3,
                                        input logic [1:0] off);
    word_t lane;
    lane = w >> {off, 3'b000};
    case (f3)
      F3_BYTE:   return {{24{lane[7]}}, lane[7:0]};
      F3_BYTE_U: return {24'h0, lane[7:0]};
      F3_HALF:   return {{16{lane[15]}}, lane[15:0]};
      F3_HALF_U: return {16'h0, lane[15:0]};
      default:   return w;
    endcase
  endfunction

  task automatic add_row(input word_t code, input word_t ld, input word_t addr,
                         input word_t wdata, input byte_en_t be, input logic hlt,
                         input logic mem_check);
    row_t r;
    r = '{pc: prog_pc, insn: code, load_data: ld, addr: addr, wdata: wdata, be: be,
          halt: hlt, mem_check: mem_check};
    rows.push_back(r);
    prog_pc = prog_pc + 32'd4;
  endtask

  task automatic plain_row(input word_t code);
    add_row(code, '0, '0, '0, '0, 1'b0, 1'b0);
  endtask

  // sw rs2, off(x1) with the value expected on the data port
  task automatic store_word(input reg_addr_t rs2, input logic [11:0] off, input word_t value);
    add_row(s_type(F3_WORD, rs2, 5'd1, off), '0, BASE + {{20{off[11]}}, off}, value,
            4'hf, 1'b0, 1'b1);
  endtask

  // result lands in x7 and is stored right after
  task automatic compute_and_store(input word_t code, input word_t value);
    plain_row(code);
    store_word(5'd7, 12'd32, value);
  endtask

  task automatic load_then_store(input funct3_t f3, input logic [1:0] off);
    word_t w;
    random_word(w);
    add_row(i_type(OP_LOAD, f3, 5'd10, 5'd1, {10'h0, off}), w, BASE + off, '0, '0,
            1'b0, 1'b1);
    store_word(5'd10, 12'd24, expect_load(w, f3, off));
  endtask

  // every branch jumps forward by 12 when taken
  task automatic branch_row(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2,
                            input logic taken);
    word_t here;
    here = prog_pc;
    plain_row(b_type(f3, rs1, rs2, 13'd12));
    if (taken) begin
      prog_pc = here + 32'd12;
    end
  endtask

  task automatic build_program();
    word_t here;
    plain_row(u_type(OP_LUI, 5'd1, 20'h00001));
    plain_row(u_type(OP_LUI, 5'd2, 20'h12345));
    store_word(5'd2, 12'd0, 32'h1234_5000);
    here = prog_pc;
    plain_row(u_type(OP_AUIPC, 5'd3, 20'h00002));
    store_word(5'd3, 12'd4, here + 32'h2000);
    // positive x4 and negative x5 with a mask in x6
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd4, 5'd2, 12'h678));
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd5, 5'd0, 12'hffb));
    plain_row(u_type(OP_LUI, 5'd6, 20'h0f0f1));
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd6, 5'd6, 12'hf0f));
    store_word(5'd6, 12'd28, 32'h0f0f_0f0f);
    compute_and_store(r_type(FUNCT7_BASE, F3_ADD_SUB, 5'd7, 5'd4, 5'd5), 32'h1234_5673);
    compute_and_store(r_type(FUNCT7_ALT, F3_ADD_SUB, 5'd7, 5'd5, 5'd4), 32'hedcb_a983);
    compute_and_store(r_type(FUNCT7_BASE, F3_AND, 5'd7, 5'd4, 5'd6), 32'h0204_0608);
    compute_and_store(r_type(FUNCT7_BASE, F3_OR, 5'd7, 5'd4, 5'd6), 32'h1f3f_5f7f);
    plain_row(r_type(FUNCT7_BASE, F3_XOR, 5'd7, 5'd4, 5'd6));
    store_word(5'd7, 12'hffc, 32'h1d3b_5977);
    // shifts and compares
    compute_and_store(i_type(OP_IMM, F3_SLL, 5'd7, 5'd4, 12'h004), 32'h2345_6780);
    compute_and_store(i_type(OP_IMM, F3_SRL_SRA, 5'd7, 5'd5, 12'h004), 32'h0fff_ffff);
    compute_and_store(i_type(OP_IMM, F3_SRL_SRA, 5'd7, 5'd5, {FUNCT7_ALT, 5'd1}),
                      32'hffff_fffd);
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd8, 5'd0, 12'd8));
    compute_and_store(r_type(FUNCT7_BASE, F3_SLL, 5'd7, 5'd4, 5'd8), 32'h3456_7800);
    compute_and_store(r_type(FUNCT7_BASE, F3_SRL_SRA, 5'd7, 5'd5, 5'd8), 32'h00ff_ffff);
    compute_and_store(r_type(FUNCT7_ALT, F3_SRL_SRA, 5'd7, 5'd5, 5'd8), 32'hffff_ffff);
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd9, 5'd0, 12'd36));
    compute_and_store(r_type(FUNCT7_BASE, F3_SLL, 5'd7, 5'd4, 5'd9), 32'h2345_6780);
    compute_and_store(r_type(FUNCT7_BASE, F3_SLT, 5'd7, 5'd5, 5'd4), 32'd1);
    compute_and_store(r_type(FUNCT7_BASE, F3_SLTU, 5'd7, 5'd5, 5'd4), 32'd0);
    compute_and_store(i_type(OP_IMM, F3_SLT, 5'd7, 5'd5, 12'hffc), 32'd1);
    compute_and_store(i_type(OP_IMM, F3_SLTU, 5'd7, 5'd4, 12'hfff), 32'd1);
    compute_and_store(i_type(OP_IMM, F3_SLTU, 5'd7, 5'd5, 12'd12), 32'd0);
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, 12'd123));
    store_word(5'd0, 12'd36, 32'd0);
    // loads at every lane offset
    for (int off = 0; off < 4; off++) begin
      load_then_store(F3_BYTE, off[1:0]);
      load_then_store(F3_BYTE_U, off[1:0]);
    end
    for (int off = 0; off < 4; off += 2) begin
      load_then_store(F3_HALF, off[1:0]);
      load_then_store(F3_HALF_U, off[1:0]);
    end
    load_then_store(F3_WORD, 2'd0);
    // narrow stores of x4
    for (int off = 0; off < 4; off++) begin
      add_row(s_type(F3_BYTE, 5'd4, 5'd1, off[11:0]), '0, BASE + off, {4{8'h78}},
              {off == 3, off == 2, off == 1, off == 0}, 1'b0, 1'b1);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_row(s_type(F3_HALF, 5'd4, 5'd1, off[11:0]), '0, BASE + off, {2{16'h5678}},
              4'b0011 << off, 1'b0, 1'b1);
    end
    branch_row(F3_BEQ, 5'd4, 5'd4, 1'b1);
    branch_row(F3_BEQ, 5'd4, 5'd5, 1'b0);
    branch_row(F3_BNE, 5'd4, 5'd5, 1'b1);
    branch_row(F3_BNE, 5'd4, 5'd4, 1'b0);
    branch_row(F3_BLT, 5'd5, 5'd4, 1'b1);
    branch_row(F3_BLT, 5'd4, 5'd5, 1'b0);
    branch_row(F3_BGE, 5'd4, 5'd5, 1'b1);
    branch_row(F3_BGE, 5'd5, 5'd4, 1'b0);
    branch_row(F3_BLTU, 5'd4, 5'd5, 1'b1);
    branch_row(F3_BLTU, 5'd5, 5'd4, 1'b0);
    branch_row(F3_BGEU, 5'd5, 5'd4, 1'b1);
    branch_row(F3_BGEU, 5'd4, 5'd5, 1'b0);
    // jal forward by 16 with the link stored afterwards
    here = prog_pc;
    plain_row(j_type(5'd11, 21'd16));
    prog_pc = here + 32'd16;
    store_word(5'd11, 12'd40, here + 32'd4);
    // jalr to an odd sum that loses bit 0
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd12, 5'd0, 12'h2fe));
    here = prog_pc;
    plain_row(i_type(OP_JALR, 3'b000, 5'd13, 5'd12, 12'd3));
    prog_pc = (32'h2fe + 32'd3) & ~32'd1;
    store_word(5'd13, 12'd44, here + 32'd4);
    add_row(32'h0000_0073, '0, '0, '0, '0, 1'b1, 1'b0);
    plain_row(32'h0000_000f);
    plain_row(i_type(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, 12'd0));
  endtask

  task automatic check_value(input string name, input int row, input word_t got,
                             input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: %s in row %0d is %h, expected %h", name, row, got, exp);
    end
  endtask

  initial begin
    row_t cur;
    int   prop_failures;
    rst       = 1'b1;
    insn      = '0;
    load_data = '0;
    build_program();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      cur = rows[i];
      check_value("pc", i, pc, cur.pc);
      insn      = cur.insn;
      load_data = cur.load_data;
      #1;
      check_value("halt", i, halt, cur.halt);
      check_value("dmem.be", i, dmem.be, cur.be);
      if (cur.mem_check) begin
        check_value("dmem.addr", i, dmem.addr, cur.addr);
        check_value("dmem.wdata", i, dmem.wdata, cur.wdata);
      end
    end
    // let the last row pass one rising edge for the bound assertions
    @(negedge clk);
    prop_failures = u_riscv_core.u_riscv_core_properties.failures;
    $display("checks %0d, value errors %0d, property failures %0d",
             checks, errors, prop_failures);
    if (errors == 0 && prop_failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // one clock period for each row and each reset cycle plus a small margin
  initial begin
    wait (table_ready);
    #((rows.size() + 8 + 4) * 8);
    $display("watchdog expired before the program table was finished");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- verification/riscv_core_properties.sv
`timescale 1ns/100ps

module riscv_core_properties (
  input logic                   clk,
  input logic                   rst,
  input rv_isa_pkg::word_t      insn,
  input rv_isa_pkg::word_t      pc,
  input rv_core_pkg::dmem_req_t dmem,
  input logic                   halt
);
  import rv_isa_pkg::*;

  int failures = 0;

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc %h is not word aligned", pc);
      failures++;
    end

  // single byte, aligned halfword, full word or nothing
  be_legal: assert property (@(posedge clk) disable iff (rst)
    dmem.be inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
    else begin
      $error("byte enable pattern %h is not legal", dmem.be);
      failures++;
    end

  halt_no_write: assert property (@(posedge clk) disable iff (rst) halt |-> dmem.be == '0)
    else begin
      $error("byte enables %h raised during halt", dmem.be);
      failures++;
    end

  be_only_store: assert property (@(posedge clk) disable iff (rst)
    insn[6:0] != OP_STORE |-> dmem.be == '0)
    else begin
      $error("byte enables %h raised by a non-store %h", dmem.be, insn);
      failures++;
    end

endmodule

bind riscv_core riscv_core_properties u_riscv_core_properties (
  .clk  (clk),
  .rst  (rst),
  .insn (insn),
  .pc   (pc),
  .dmem (dmem),
  .halt (halt)
);

//--- hdl/riscv_core.sv
`timescale 1ns/100ps

module riscv_core #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input                          clk,
  input                          rst,
  input  rv_isa_pkg::word_t      insn,
  input  rv_isa_pkg::word_t      load_data,
  output rv_isa_pkg::word_t      pc,
  output rv_core_pkg::dmem_req_t dmem,
  output logic                   halt
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t pc_plus4;
  word_t load_value;
  word_t wb_data;

  insn_decoder u_insn_decoder (
    .insn (insn),
    .ctrl (ctrl)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rd       (ctrl.rd),
    .rd_data  (wb_data),
    .we       (ctrl.reg_we),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // pc as operand a only for auipc
  assign alu_a = ctrl.use_pc ? pc : rs1_data;
  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  // effective address comes out of the alu as rs1 plus immediate
  lsu u_lsu (
    .ctrl        (ctrl),
    .addr        (alu_result),
    .store_value (rs2_data),
    .load_data   (load_data),
    .dmem        (dmem),
    .load_value  (load_value)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD: wb_data = load_value;
      WB_PC4:  wb_data = pc_plus4;
      WB_IMM:  wb_data = ctrl.imm;
      default: wb_data = alu_result;
    endcase
  end

  assign halt = ctrl.is_ecall;

endmodule

//--- hdl/lsu.sv
`timescale 1ns/100ps

module lsu (
  input  rv_core_pkg::ctrl_t     ctrl,
  input  rv_isa_pkg::word_t      addr,
  input  rv_isa_pkg::word_t      store_value,
  input  rv_isa_pkg::word_t      load_data,
  output rv_core_pkg::dmem_req_t dmem,
  output rv_isa_pkg::word_t      load_value
);
  import rv_isa_pkg::*;

  word_t       store_wdata;
  byte_en_t    store_be;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // store data goes to every lane, the enables pick the bytes that land
  always_comb begin
    store_wdata = '0;
    store_be    = '0;
    if (ctrl.is_store) begin
      case (ctrl.funct3)
        F3_BYTE: begin
          store_wdata = {4{store_value[7:0]}};
          store_be    = 4'b0001 << addr[1:0];
        end
        F3_HALF: begin
          store_wdata = {2{store_value[15:0]}};
          store_be    = addr[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
          store_wdata = store_value;
          store_be    = 4'b1111;
        end
      endcase
    end
  end

  assign dmem = '{addr: addr, wdata: store_wdata, be: store_be};

  // lane select for loads
  always_comb begin
    case (addr[1:0])
      2'b00:   lane_byte = load_data[7:0];
      2'b01:   lane_byte = load_data[15:8];
      2'b10:   lane_byte = load_data[23:16];
      default: lane_byte = load_data[31:24];
    endcase
  end

  assign lane_half = addr[1] ? load_data[31:16] : load_data[15:0];

  always_comb begin
    case (ctrl.funct3)
      F3_BYTE:   load_value = {{24{lane_byte[7]}}, lane_byte};
      F3_HALF:   load_value = {{16{lane_half[15]}}, lane_half};
      F3_BYTE_U: load_value = {24'b0, lane_byte};
      F3_HALF_U: load_value = {16'b0, lane_half};
      default:   load_value = load_data;
    endcase
  end

endmodule

//--- hdl/pc_unit.sv
`timescale 1ns/100ps

module pc_unit #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input                      clk,
  input                      rst,
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_isa_pkg::word_t  rs1_data,
  input  rv_isa_pkg::word_t  rs2_data,
  output rv_isa_pkg::word_t  pc,
  output rv_isa_pkg::word_t  pc_plus4
);
  import rv_isa_pkg::*;

  logic  taken;
  word_t jalr_sum;
  word_t next_pc;

  // branch condition on the two register values
  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  taken = rs1_data == rs2_data;
      F3_BNE:  taken = rs1_data != rs2_data;
      F3_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
      F3_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      F3_BLTU: taken = rs1_data < rs2_data;
      F3_BGEU: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;
  assign jalr_sum = rs1_data + ctrl.imm;

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = {jalr_sum[31:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
      next_pc = pc + ctrl.imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu (
  input  rv_core_pkg::alu_op_e op,
  input  rv_isa_pkg::word_t    a,
  input  rv_isa_pkg::word_t    b,
  output rv_isa_pkg::word_t    result
);
  import rv_core_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {31'b0, lt_signed};
      ALU_SLTU: result = {31'b0, lt_unsigned};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input                         clk,
  input                         rst,
  input  rv_isa_pkg::reg_addr_t rd,
  input  rv_isa_pkg::word_t     rd_data,
  input                         we,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;

  localparam int NUM_REGS = 32;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // x0 is never written so it keeps reading zero
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- hdl/insn_decoder.sv
`timescale 1ns/100ps

module insn_decoder (
  input  rv_isa_pkg::word_t  insn,
  output rv_core_pkg::ctrl_t ctrl
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_u;
  word_t     imm_j;
  alu_op_e   alu_sel;
  logic      reg_f7_ok;
  logic      imm_f7_ok;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  // funct7 must be base, or alt for sub and the arithmetic shift
  assign reg_f7_ok = (funct7 == FUNCT7_BASE) ||
                     (funct7 == FUNCT7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
  assign imm_f7_ok = (funct3 == F3_SLL) ? (funct7 == FUNCT7_BASE) :
                     (funct3 == F3_SRL_SRA) ? (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT) :
                     1'b1;

  // alu operation shared by register and immediate forms
  always_comb begin
    case (funct3)
      F3_ADD_SUB: alu_sel = (opcode == OP_REG && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_sel = ALU_SLL;
      F3_SLT:     alu_sel = ALU_SLT;
      F3_SLTU:    alu_sel = ALU_SLTU;
      F3_XOR:     alu_sel = ALU_XOR;
      F3_SRL_SRA: alu_sel = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_sel = ALU_OR;
      default:    alu_sel = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.wb_sel = WB_ALU;
    ctrl.funct3 = funct3;
    ctrl.rd     = rd;
    ctrl.rs1    = rs1;
    ctrl.rs2    = rs2;
    case (opcode)
      OP_LUI: begin
        ctrl.imm    = imm_u;
        ctrl.wb_sel = WB_IMM;
        ctrl.reg_we = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.imm     = imm_u;
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
      end
      OP_JAL: begin
        ctrl.imm    = imm_j;
        ctrl.is_jal = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.reg_we = 1'b1;
      end
      OP_JALR: begin
        // only funct3 zero is defined
        if (funct3 == 3'b000) begin
          ctrl.imm     = imm_i;
          ctrl.is_jalr = 1'b1;
          ctrl.wb_sel  = WB_PC4;
          ctrl.reg_we  = 1'b1;
        end
      end
      OP_BRANCH: begin
        if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
          ctrl.imm       = imm_b;
          ctrl.is_branch = 1'b1;
        end
      end
      OP_LOAD: begin
        if (funct3 inside {F3_BYTE, F3_HALF, F3_WORD, F3_BYTE_U, F3_HALF_U}) begin
          ctrl.imm     = imm_i;
          ctrl.use_imm = 1'b1;
          ctrl.is_load = 1'b1;
          ctrl.wb_sel  = WB_LOAD;
          ctrl.reg_we  = 1'b1;
        end
      end
      OP_STORE: begin
        if (funct3 inside {F3_BYTE, F3_HALF, F3_WORD}) begin
          ctrl.imm      = imm_s;
          ctrl.use_imm  = 1'b1;
          ctrl.is_store = 1'b1;
        end
      end
      OP_IMM: begin
        if (imm_f7_ok) begin
          ctrl.imm     = imm_i;
          ctrl.alu_op  = alu_sel;
          ctrl.use_imm = 1'b1;
          ctrl.reg_we  = 1'b1;
        end
      end
      OP_REG: begin
        if (reg_f7_ok) begin
          ctrl.alu_op = alu_sel;
          ctrl.reg_we = 1'b1;
        end
      end
      OP_MISC_MEM: begin
        // fence has nothing to order in this core
      end
      OP_SYSTEM: begin
        if (insn[31:7] == '0) begin
          ctrl.is_ecall = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

  // operations the ALU can perform
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // source of the value written to rd
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4,
    WB_IMM
  } wb_sel_e;

  // decoded control for one instruction
  typedef struct packed {
    alu_op_e              alu_op;
    logic                 use_imm;
    logic                 use_pc;
    wb_sel_e              wb_sel;
    logic                 reg_we;
    logic                 is_load;
    logic                 is_store;
    logic                 is_branch;
    logic                 is_jal;
    logic                 is_jalr;
    logic                 is_ecall;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
  } ctrl_t;

  // data port request, be is zero when nothing is written
  typedef struct packed {
    rv_isa_pkg::word_t    addr;
    rv_isa_pkg::word_t    wdata;
    rv_isa_pkg::byte_en_t be;
  } dmem_req_t;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  // architectural widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [3:0]  byte_en_t;

  // major opcodes
  localparam opcode_t OP_LUI      = 7'b0110111;
  localparam opcode_t OP_AUIPC    = 7'b0010111;
  localparam opcode_t OP_JAL      = 7'b1101111;
  localparam opcode_t OP_JALR     = 7'b1100111;
  localparam opcode_t OP_BRANCH   = 7'b1100011;
  localparam opcode_t OP_LOAD     = 7'b0000011;
  localparam opcode_t OP_STORE    = 7'b0100011;
  localparam opcode_t OP_IMM      = 7'b0010011;
  localparam opcode_t OP_REG      = 7'b0110011;
  localparam opcode_t OP_MISC_MEM = 7'b0001111;
  localparam opcode_t OP_SYSTEM   = 7'b1110011;

  // branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // load and store sizes, the _U forms are zero extended loads
  localparam funct3_t F3_BYTE   = 3'b000;
  localparam funct3_t F3_HALF   = 3'b001;
  localparam funct3_t F3_WORD   = 3'b010;
  localparam funct3_t F3_BYTE_U = 3'b100;
  localparam funct3_t F3_HALF_U = 3'b101;

  // integer operations, shared by the register and immediate forms
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct7 variants
  localparam funct7_t FUNCT7_BASE = 7'b0000000;
  localparam funct7_t FUNCT7_ALT  = 7'b0100000;

endpackage
